//--- fabCfg_consts.svh
`ifndef FABCFG_CONSTS_SVH
`define FABCFG_CONSTS_SVH

// pattern that must be seen before any header is accepted
`define FAB_SYNC_WORD 32'hFAB0_FAB1

// data words per frame, one per row
`define FAB_ROWS 4

// row index width, all ones means no row
`define FAB_ROW_BITS 3

// word buffer between assembler and FSM
`define FAB_FIFO_DEPTH 4
`define FAB_FIFO_PTR_BITS 2

`endif

//--- fabCfgPkg.sv
package fabCfgPkg;

	// field view of a header word
	typedef struct packed {
		logic [10:0] reserved; // bits 31..21, unused
		logic desync; // bit 20, drop back to unsynced
		logic [19:0] frameIndex; // frame number inside the fabric
	} cfgHeaderFields_s;

	// one header word, read either as a whole address or by fields
	typedef union packed {
		logic [31:0] raw; // full word, stored as frame address
		cfgHeaderFields_s fields; // decoded view
	} cfgHeader_u;

	// configuration FSM states
	typedef enum logic [1:0] {
		unsynced = 2'd0, // hunting for the sync word
		header = 2'd1, // next word is a header
		frameData = 2'd2 // shifting row words
	} cfgState_e;

endpackage

//--- frameWriteIf.sv
`include "fabCfg_consts.svh"

interface frameWriteIf;
	logic rowWrite; // one pulse per data word
	logic [`FAB_ROW_BITS-1:0] rowSelect; // row count, all ones when idle
	logic [31:0] rowWord; // data word for the selected row
	logic frameStrobe; // last row of the frame
	logic [31:0] frameAddress; // header of the current frame

	modport fsm (
		output rowWrite,
		output rowSelect,
		output rowWord,
		output frameStrobe,
		output frameAddress
	);

	modport latch (
		input rowWrite,
		input rowSelect,
		input rowWord,
		input frameStrobe,
		input frameAddress
	);
endinterface

//--- byteAssembler.sv
module byteAssembler (
	input logic CLK,
	input logic arstN,
	input logic [7:0] byteData,
	input logic byteValid,
	output logic byteReady,
	output logic wordReq,
	input logic wordAck,
	output logic [31:0] wordData
);
	logic [1:0] byteCount; // bytes collected so far
	logic full; // word complete, link owns it
	logic ackSeen; // receiver has taken the word
	logic byteTake;

	assign byteReady = !full; // no bytes while the word is in flight
	assign byteTake = byteValid && byteReady;

	// msb first, so each new byte pushes the older ones up
	always_ff @(posedge CLK) begin
		if (byteTake) begin
			wordData <= {wordData[23:0], byteData};
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			byteCount <= 2'd0;
			full <= 1'b0;
			wordReq <= 1'b0;
			ackSeen <= 1'b0;
		end else begin
			if (byteTake) begin
				byteCount <= byteCount + 2'd1; // wraps after the fourth byte
				if (byteCount == 2'd3) begin
					full <= 1'b1;
				end
			end

			// four-phase sender side
			if (full && !wordReq && !ackSeen && !wordAck) begin
				wordReq <= 1'b1; // data already stable
			end else if (wordReq && wordAck) begin
				wordReq <= 1'b0;
				ackSeen <= 1'b1;
			end else if (ackSeen && !wordAck) begin
				// link back to idle, reopen the byte port
				ackSeen <= 1'b0;
				full <= 1'b0;
			end
		end
	end

endmodule

//--- wordFifo.sv
`include "fabCfg_consts.svh"

module wordFifo (
	input logic CLK,
	input logic arstN,
	input logic inReq,
	output logic inAck,
	input logic [31:0] inData,
	output logic outReq,
	input logic outAck,
	output logic [31:0] outData
);
	logic [31:0] mem [0:`FAB_FIFO_DEPTH-1];
	logic [`FAB_FIFO_PTR_BITS-1:0] wrPtr;
	logic [`FAB_FIFO_PTR_BITS-1:0] rdPtr;
	logic [`FAB_FIFO_PTR_BITS:0] count; // one extra bit to hold full depth
	logic outDone; // receiver acked, waiting for ack to drop
	logic push;
	logic pop;

	// new req, not yet acked, and a free slot
	assign push = inReq && !inAck && (count != (`FAB_FIFO_PTR_BITS+1)'(`FAB_FIFO_DEPTH));
	// head leaves once the output handshake has fully closed
	assign pop = outDone && !outAck;
	assign outData = mem[rdPtr]; // head word, stable while outReq is high

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			inAck <= 1'b0;
			outReq <= 1'b0;
			outDone <= 1'b0;
		end else begin
			// input side, ack withheld while full
			if (push) begin
				inAck <= 1'b1;
				wrPtr <= wrPtr + 1'b1;
			end else if (inAck && !inReq) begin
				inAck <= 1'b0;
			end

			// output side
			if (!outReq && !outDone && !outAck && count != '0) begin
				outReq <= 1'b1;
			end else if (outReq && outAck) begin
				outReq <= 1'b0;
				outDone <= 1'b1;
			end else if (pop) begin
				outDone <= 1'b0;
				rdPtr <= rdPtr + 1'b1;
			end

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

//--- configFsm.sv
`include "fabCfg_consts.svh"

module configFsm (
	input logic CLK,
	input logic arstN,
	input logic comActive,
	input logic wordReq,
	output logic wordAck,
	input logic [31:0] wordData,
	frameWriteIf.fsm frameWr
);
	fabCfgPkg::cfgState_e state;
	fabCfgPkg::cfgHeader_u hdr;
	logic [`FAB_ROW_BITS-1:0] rowCount; // rows left in this frame
	logic [31:0] addrReg; // last accepted header
	logic comActiveQ;
	logic restart;
	logic take;
	logic act;

	assign hdr.raw = wordData; // same word, two views
	assign restart = comActive && !comActiveQ; // com port just came up
	assign take = wordReq && !wordAck; // fresh word on the link
	assign act = take && !restart; // word dropped if it hits a restart

	// row writes go out in the cycle the word is acked
	assign frameWr.rowWrite = act && (state == fabCfgPkg::frameData);
	assign frameWr.rowSelect = frameWr.rowWrite ? rowCount : '1;
	assign frameWr.rowWord = wordData;
	assign frameWr.frameStrobe = frameWr.rowWrite && (rowCount == `FAB_ROW_BITS'(1));
	assign frameWr.frameAddress = addrReg;

	// four-phase receiver
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			wordAck <= 1'b0;
		end else if (take) begin
			wordAck <= 1'b1;
		end else if (wordAck && !wordReq) begin
			wordAck <= 1'b0; // sender released, close the cycle
		end
	end

	always_ff @(posedge CLK) begin
		if (act && state == fabCfgPkg::header && !hdr.fields.desync) begin
			addrReg <= hdr.raw;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= fabCfgPkg::unsynced;
			rowCount <= '0;
			comActiveQ <= 1'b0;
		end else begin
			comActiveQ <= comActive;
			if (restart) begin
				state <= fabCfgPkg::unsynced; // start over, partial frame lost
				rowCount <= '0;
			end else if (act) begin
				case (state)
					fabCfgPkg::unsynced: begin
						if (wordData == `FAB_SYNC_WORD) begin
							state <= fabCfgPkg::header;
						end
					end
					fabCfgPkg::header: begin
						if (hdr.fields.desync) begin
							state <= fabCfgPkg::unsynced;
						end else begin
							rowCount <= `FAB_ROW_BITS'(`FAB_ROWS);
							state <= fabCfgPkg::frameData;
						end
					end
					fabCfgPkg::frameData: begin
						rowCount <= rowCount - 1'b1;
						if (rowCount == `FAB_ROW_BITS'(1)) begin
							state <= fabCfgPkg::header; // wait for next header or desync
						end
					end
					default: state <= fabCfgPkg::unsynced;
				endcase
			end
		end
	end

endmodule

//--- frameLatch.sv
`include "fabCfg_consts.svh"

module frameLatch (
	input logic CLK,
	input logic arstN,
	frameWriteIf.latch frameWr,
	output logic [31:0] frameAddress,
	output logic [`FAB_ROWS*32-1:0] frameBits,
	output logic frameValid
);
	logic [`FAB_ROWS-1:0][31:0] rowReg; // row r lives in slot r-1
	logic [`FAB_ROWS-1:0][31:0] nextRows; // rows with this cycle's write applied
	logic strobeQ; // delayed strobe for the long pulse

	// the last row lands together with the strobe, so publish the merged view
	always_comb begin
		nextRows = rowReg;
		if (frameWr.rowWrite) begin
			for (int r = 0; r < `FAB_ROWS; r++) begin
				if (frameWr.rowSelect == `FAB_ROW_BITS'(r + 1)) begin
					nextRows[r] = frameWr.rowWord;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		rowReg <= nextRows;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			frameBits <= '0;
			frameAddress <= '0;
			strobeQ <= 1'b0;
			frameValid <= 1'b0;
		end else begin
			if (frameWr.frameStrobe) begin
				frameBits <= nextRows;
				frameAddress <= frameWr.frameAddress;
			end
			strobeQ <= frameWr.frameStrobe;
			frameValid <= frameWr.frameStrobe || strobeQ; // two cycles wide
		end
	end

endmodule

//--- fabricConfig.sv
`include "fabCfg_consts.svh"

module fabricConfig (
	input logic CLK,
	input logic arstN,
	input logic [7:0] byteData,
	input logic byteValid,
	output logic byteReady,
	input logic comActive,
	output logic [31:0] frameAddress,
	output logic [`FAB_ROWS*32-1:0] frameBits,
	output logic frameValid
);
	logic wordReq; // assembler to FIFO
	logic wordAck;
	logic [31:0] wordData;
	logic fifoReq; // FIFO to FSM
	logic fifoAck;
	logic [31:0] fifoData;

	frameWriteIf frameWr ();

	byteAssembler assembler (
		.CLK(CLK),
		.arstN(arstN),
		.byteData(byteData),
		.byteValid(byteValid),
		.byteReady(byteReady),
		.wordReq(wordReq),
		.wordAck(wordAck),
		.wordData(wordData)
	);

	wordFifo fifo (
		.CLK(CLK),
		.arstN(arstN),
		.inReq(wordReq),
		.inAck(wordAck),
		.inData(wordData),
		.outReq(fifoReq),
		.outAck(fifoAck),
		.outData(fifoData)
	);

	configFsm fsm (
		.CLK(CLK),
		.arstN(arstN),
		.comActive(comActive),
		.wordReq(fifoReq),
		.wordAck(fifoAck),
		.wordData(fifoData),
		.frameWr(frameWr.fsm)
	);

	frameLatch latch (
		.CLK(CLK),
		.arstN(arstN),
		.frameWr(frameWr.latch),
		.frameAddress(frameAddress),
		.frameBits(frameBits),
		.frameValid(frameValid)
	);

endmodule

//--- tbClock.sv
module tbClock (
	output logic CLK
);
	initial begin
		CLK = 1'b0; // first rising edge at 50
		forever #50 CLK = ~CLK; // 100 unit period
	end
endmodule

//--- fabricConfigTb.sv
`include "fabCfg_consts.svh"

module fabricConfigTb;
	logic CLK;
	logic arstN;
	logic [7:0] byteData;
	logic byteValid;
	logic byteReady;
	logic comActive;
	logic [31:0] frameAddress;
	logic [`FAB_ROWS*32-1:0] frameBits;
	logic frameValid;

	logic [31:0] words[$]; // word stream of the running test
	logic [31:0] expAddr[$]; // expected frames in publish order
	logic [`FAB_ROWS*32-1:0] expBits[$];
	string expName[$];
	int bytesSent = 0;
	int cycles = 0;
	int highCycles = 0; // length of the current frameValid pulse
	logic validQ = 1'b0;
	int modelState = 0; // 0 unsynced, 1 header, 2 row data
	int modelRows = 0; // rows still to come in this frame
	logic [31:0] modelAddr = '0;
	logic [`FAB_ROWS*32-1:0] modelBits = '0;

	tbClock clockGen (.CLK(CLK));

	fabricConfig UUT (.*);

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// walks the stream with the port's rules
	function automatic void expectedFrames(input string name);
		foreach (words[i]) begin
			if (modelState == 0) begin
				modelState = (words[i] == `FAB_SYNC_WORD) ? 1 : 0;
			end else if (modelState == 1) begin
				modelState = words[i][20] ? 0 : 2; // desync flag
				modelAddr = words[i];
				modelRows = `FAB_ROWS;
			end else begin
				modelBits[(modelRows-1)*32 +: 32] = words[i]; // row r in slice r-1
				modelRows--;
				if (modelRows == 0) begin
					expAddr.push_back(modelAddr);
					expBits.push_back(modelBits);
					expName.push_back(name);
					modelState = 1;
				end
			end
		end
	endfunction

	function automatic logic [31:0] noiseWord();
		logic [31:0] w;
		w = $urandom;
		if (w == `FAB_SYNC_WORD) begin
			w = ~w; // noise must never sync
		end
		return w;
	endfunction

	function automatic void addFrame(input logic desync);
		logic [31:0] hdr;
		hdr = $urandom;
		hdr[20] = desync;
		words.push_back(hdr);
		for (int r = 0; r < `FAB_ROWS; r++) begin
			words.push_back($urandom);
		end
	endfunction

	task automatic sendByte(input logic [7:0] b, input int gapMax);
		int gap;
		gap = (gapMax > 0) ? ($urandom % (gapMax + 1)) : 0;
		repeat (gap) begin
			byteValid <= 1'b0; // idle gap
			@(posedge CLK);
		end
		byteData <= b;
		byteValid <= 1'b1;
		do @(negedge CLK); while (!byteReady); // ready is stable at the falling edge
		@(posedge CLK); // byte taken here
		bytesSent++;
	endtask

	// wait until the whole pipe is idle and the last frame is out
	task automatic waitDrain();
		do @(negedge CLK);
		while (!(byteReady && !UUT.wordReq && UUT.fifo.count == 0 && !UUT.fifoReq && !UUT.fifoAck));
		repeat (4) @(posedge CLK);
	endtask

	task automatic sendWords(input string name, input int gapMax);
		expectedFrames(name);
		foreach (words[i]) begin
			for (int b = 3; b >= 0; b--) begin
				sendByte(words[i][b*8 +: 8], gapMax); // msb first
			end
		end
		byteValid <= 1'b0;
		words.delete();
		waitDrain();
	endtask

	task automatic pulseComActive();
		comActive <= 1'b1; // rising edge resyncs the FSM
		modelState = 0; // model restarts with the port
		@(posedge CLK);
		comActive <= 1'b0;
		@(posedge CLK);
	endtask

	task automatic compareFrame();
		assert (expAddr.size() != 0) else stopOnError("a frame was published when none was expected");
		assert (frameAddress == expAddr[0]) else stopOnError($sformatf(
			"mismatch %s address expected %h actual %h", expName[0], expAddr[0], frameAddress));
		assert (frameBits == expBits[0]) else stopOnError($sformatf(
			"mismatch %s frame expected %h actual %h", expName[0], expBits[0], frameBits));
		void'(expAddr.pop_front());
		void'(expBits.pop_front());
		void'(expName.pop_front());
	endtask

	always @(negedge CLK) begin
		if (frameValid) begin
			if (!validQ) begin
				compareFrame(); // new frame
			end
			highCycles++;
		end else if (validQ) begin
			assert (highCycles == 2) else stopOnError("frameValid did not last two cycles");
			highCycles = 0;
		end
		validQ = frameValid;
	end

	// limit grows with the bytes sent
	initial begin
		forever begin
			@(posedge CLK);
			cycles++;
			if (cycles > bytesSent * 40 + 2000) begin
				stopOnError("timeout, the port stopped taking bytes or publishing frames");
			end
		end
	end

	initial begin
		void'($urandom(88));
		arstN = 1'b0;
		byteData = 8'h00;
		byteValid = 1'b0;
		comActive = 1'b0;
		repeat (5) @(posedge CLK);
		arstN <= 1'b1;
		@(negedge CLK);
		assert (byteReady === 1'b1) else stopOnError($sformatf(
			"mismatch reset byteReady expected 1 actual %b", byteReady));
		assert (frameValid === 1'b0) else stopOnError($sformatf(
			"mismatch reset frameValid expected 0 actual %b", frameValid));
		assert (frameBits === '0) else stopOnError($sformatf(
			"mismatch reset frameBits expected 0 actual %h", frameBits));
		@(posedge CLK);

		words.push_back(`FAB_SYNC_WORD);
		addFrame(1'b0);
		sendWords("singleFrame", 2);

		pulseComActive();
		repeat (8) words.push_back(noiseWord());
		words.push_back(noiseWord() | 32'h0010_0000); // bit 20 set
		sendWords("preSyncNoise", 2);

		pulseComActive();
		words.push_back(`FAB_SYNC_WORD);
		repeat (3) addFrame(1'b0);
		sendWords("backToBackFrames", 2);

		pulseComActive();
		words.push_back(`FAB_SYNC_WORD);
		words.push_back(noiseWord() | 32'h0010_0000); // desync header
		addFrame(1'b0); // ignored while unsynced
		words.push_back(`FAB_SYNC_WORD);
		addFrame(1'b0);
		sendWords("desyncThenNoise", 2);

		pulseComActive();
		words.push_back(`FAB_SYNC_WORD);
		repeat (3) addFrame(1'b0);
		sendWords("backPressure", 0); // valid held high
		repeat (2) addFrame(1'b0); // port still waits for a header
		sendWords("backPressure", 3);

		pulseComActive();
		words.push_back(`FAB_SYNC_WORD);
		words.push_back(noiseWord() & ~32'h0010_0000);
		repeat (2) words.push_back($urandom); // half a frame
		sendWords("comActiveRestart", 1);
		pulseComActive(); // partial frame dropped
		words.push_back(`FAB_SYNC_WORD);
		addFrame(1'b0);
		sendWords("comActiveRestart", 1);

		assert (expAddr.size() == 0) else stopOnError("expected frames were never published");
		$display("*** PASSED ***");
		$finish;
	end
endmodule

//--- fabricConfig.f
+incdir+.
fabCfgPkg.sv
frameWriteIf.sv
byteAssembler.sv
wordFifo.sv
configFsm.sv
frameLatch.sv
fabricConfig.sv
tbClock.sv
fabricConfigTb.sv
